// ==== capture_defs.svh ====
`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// one I or Q sample
`define SAMPLE_W 16

// one capture word, two 32-bit halves
`define WORD_W 64

// cycles the capture enable is held after a chirp start
// or after the ADC enable falls
`define DDS_LATENCY 2

// converter loop delay, in samples
`define ADC_DELAY 100

`endif

// ==== capture_pkg.sv ====
`default_nettype none

`include "capture_defs.svh"

package capture_pkg;

  // signed converter sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // I in the upper half, Q in the lower half
  typedef logic [2*`SAMPLE_W-1:0] iq_t;

  // capture word, upper and lower halves routed separately
  typedef logic [`WORD_W-1:0] word_t;

  // source of one half of the capture word
  typedef enum logic [1:0] {
    ROUTE_ADC          = 2'd0,
    ROUTE_DAC          = 2'd1,
    ROUTE_SAMPLE_COUNT = 2'd2,
    // low 32 bits of the free-running counter
    ROUTE_CYCLE_COUNT  = 2'd3
  } route_sel_t;

endpackage

`default_nettype wire

// ==== loopback_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module loopback_model (
  input  logic                 clk_245_76MHz,
  input  logic                 cpu_reset,
  input  capture_pkg::sample_t dds_i_i,
  input  capture_pkg::sample_t dds_q_i,
  output capture_pkg::iq_t     dac_iq_o,
  output capture_pkg::iq_t     adc_iq_o,
  output logic                 sample_valid_o
);

  import capture_pkg::*;

  iq_t     dac_iq_q;
  sample_t dac_i;
  sample_t dac_q;
  sample_t half_i;
  sample_t half_q;
  iq_t     adc_dly_q [`ADC_DELAY];
  logic    valid_q;

  // DAC output register stage
  always_ff @(posedge clk_245_76MHz) begin
    dac_iq_q <= {dds_i_i, dds_q_i};
  end

  // board attenuation, each sample halved with its sign kept
  always_comb begin
    {dac_i, dac_q} = dac_iq_q;
    half_i = dac_i >>> 1;
    half_q = dac_q >>> 1;
  end

  // ADC path delay line
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      for (int k = 0; k < `ADC_DELAY; k++) begin
        adc_dly_q[k] <= '0;
      end
    end else begin
      adc_dly_q[0] <= {half_i, half_q};
      for (int k = 1; k < `ADC_DELAY; k++) begin
        adc_dly_q[k] <= adc_dly_q[k-1];
      end
    end
  end

  // converter reports valid data from the first cycle out of reset
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  assign dac_iq_o       = dac_iq_q;
  assign adc_iq_o       = adc_dly_q[`ADC_DELAY-1];
  assign sample_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== enable_gate.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module enable_gate (
  input  logic clk_245_76MHz,
  input  logic cpu_reset,
  input  logic adc_enable_i,
  input  logic chirp_init_i,
  input  logic sample_valid_i,
  output logic wr_en_o,
  output logic first_o,
  output logic last_o
);

  localparam int HOLD_W = $clog2(`DDS_LATENCY + 1);

  logic              en_sync_q;
  logic              cap_en_q;
  logic [HOLD_W-1:0] hold_cnt_q;
  logic              hold_zero;
  logic              en_fall;
  logic              first_q;

  assign hold_zero = (hold_cnt_q == '0);

  // enable dropping this cycle
  assign en_fall = en_sync_q & ~adc_enable_i;

  // enable synchronizer
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_sync_q <= 1'b0;
    end else begin
      en_sync_q <= adc_enable_i;
    end
  end

  // hold off changes until the DDS pipeline has flushed
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      hold_cnt_q <= '0;
    end else if (chirp_init_i || en_fall) begin
      hold_cnt_q <= HOLD_W'(`DDS_LATENCY);
    end else if (!hold_zero) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // capture enable follows the synchronized enable only when not holding
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      cap_en_q <= 1'b0;
    end else if (hold_zero) begin
      cap_en_q <= en_sync_q;
    end
  end

  // marks the cycle capture turns on
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      first_q <= 1'b0;
    end else begin
      first_q <= hold_zero & en_sync_q & ~cap_en_q;
    end
  end

  assign wr_en_o = cap_en_q & sample_valid_i;
  assign first_o = first_q;

  // final word, capture about to drop on the next edge
  assign last_o = hold_zero & cap_en_q & ~en_sync_q;

endmodule

`default_nettype wire

// ==== capture_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_counters (
  input  logic        clk_245_76MHz,
  input  logic        cpu_reset,
  input  logic        wr_en_i,
  output logic [63:0] cycle_count_o,
  output logic [31:0] sample_count_o
);

  logic [63:0] cycle_cnt_q;
  logic [31:0] sample_cnt_q;

  // timestamp base, free running
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      cycle_cnt_q <= '0;
    end else begin
      cycle_cnt_q <= cycle_cnt_q + 64'd1;
    end
  end

  // counts every captured word, keeps going across bursts
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt_q <= '0;
    end else if (wr_en_i) begin
      sample_cnt_q <= sample_cnt_q + 32'd1;
    end
  end

  assign cycle_count_o  = cycle_cnt_q;
  assign sample_count_o = sample_cnt_q;

endmodule

`default_nettype wire

// ==== capture_word_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_word_mux (
  input  capture_pkg::route_sel_t route_lower_i,
  input  capture_pkg::route_sel_t route_upper_i,
  input  capture_pkg::iq_t        adc_iq_i,
  input  capture_pkg::iq_t        dac_iq_i,
  input  logic [31:0]             cycle_count_i,
  input  logic [31:0]             sample_count_i,
  input  logic                    first_i,
  input  logic                    last_i,
  output capture_pkg::word_t      word_o
);

  import capture_pkg::*;

  logic [31:0] upper_half;
  logic [31:0] lower_half;

  // one half-word source per route code
  function automatic logic [31:0] pick_half(
    input route_sel_t  sel,
    input iq_t         adc_iq,
    input iq_t         dac_iq,
    input logic [31:0] cycle_cnt,
    input logic [31:0] sample_cnt
  );
    logic [31:0] half;
    case (sel)
      ROUTE_ADC:          half = adc_iq;
      ROUTE_DAC:          half = dac_iq;
      ROUTE_SAMPLE_COUNT: half = sample_cnt;
      ROUTE_CYCLE_COUNT:  half = cycle_cnt;
      default:            half = adc_iq;
    endcase
    return half;
  endfunction

  always_comb begin
    upper_half = pick_half(route_upper_i, adc_iq_i, dac_iq_i, cycle_count_i, sample_count_i);
    lower_half = pick_half(route_lower_i, adc_iq_i, dac_iq_i, cycle_count_i, sample_count_i);

    // burst edges carry the timestamp header instead of data
    if (first_i || last_i) begin
      word_o = {cycle_count_i, sample_count_i};
    end else begin
      word_o = {upper_half, lower_half};
    end
  end

endmodule

`default_nettype wire

// ==== capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_top (
  input  logic                    clk_245_76MHz,
  input  logic                    cpu_reset,
  // chirp DDS samples
  input  capture_pkg::sample_t    dds_i_i,
  input  capture_pkg::sample_t    dds_q_i,
  input  logic                    adc_enable_i,
  input  logic                    chirp_init_i,
  // half-word source selects
  input  capture_pkg::route_sel_t route_lower_i,
  input  capture_pkg::route_sel_t route_upper_i,
  output capture_pkg::word_t      capture_word_o,
  output logic                    capture_valid_o,
  output logic                    capture_first_o,
  output logic                    capture_last_o
);

  import capture_pkg::*;

  iq_t         dac_iq;
  iq_t         adc_iq;
  logic        sample_valid;
  logic        wr_en;
  logic        wr_first;
  logic        wr_last;
  logic [63:0] cycle_count;
  logic [31:0] sample_count;

  // converter board stand-in
  loopback_model u_loopback_model (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .dds_i_i        (dds_i_i),
    .dds_q_i        (dds_q_i),
    .dac_iq_o       (dac_iq),
    .adc_iq_o       (adc_iq),
    .sample_valid_o (sample_valid)
  );

  // burst framing
  enable_gate u_enable_gate (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .adc_enable_i   (adc_enable_i),
    .chirp_init_i   (chirp_init_i),
    .sample_valid_i (sample_valid),
    .wr_en_o        (wr_en),
    .first_o        (wr_first),
    .last_o         (wr_last)
  );

  capture_counters u_capture_counters (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .wr_en_i        (wr_en),
    .cycle_count_o  (cycle_count),
    .sample_count_o (sample_count)
  );

  // headers use only the low timestamp bits
  capture_word_mux u_capture_word_mux (
    .route_lower_i  (route_lower_i),
    .route_upper_i  (route_upper_i),
    .adc_iq_i       (adc_iq),
    .dac_iq_i       (dac_iq),
    .cycle_count_i  (cycle_count[31:0]),
    .sample_count_i (sample_count),
    .first_i        (wr_first),
    .last_i         (wr_last),
    .word_o         (capture_word_o)
  );

  assign capture_valid_o = wr_en;
  assign capture_first_o = wr_first;
  assign capture_last_o  = wr_last;

endmodule

`default_nettype wire

// ==== tb_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module tb_capture_top;

  import capture_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int N_BURST    = 5;
  localparam int HIST_OFS   = `ADC_DELAY + 2;
  localparam int HIST_DEPTH = 1024;

  logic       clk_245_76MHz;
  logic       cpu_reset;
  sample_t    dds_i;
  sample_t    dds_q;
  logic       adc_enable;
  logic       chirp_init;
  route_sel_t route_lower;
  route_sel_t route_upper;
  word_t      capture_word;
  logic       capture_valid;
  logic       capture_first;
  logic       capture_last;

  integer      seed;
  logic [3:0]  route_step;
  iq_t         hist_mem [HIST_DEPTH];
  logic [31:0] tb_cycle;
  logic [31:0] tb_samples;
  int          burst_words;
  int          exp_len;
  int          bursts_done;

  capture_top dut (
    .clk_245_76MHz   (clk_245_76MHz),
    .cpu_reset       (cpu_reset),
    .dds_i_i         (dds_i),
    .dds_q_i         (dds_q),
    .adc_enable_i    (adc_enable),
    .chirp_init_i    (chirp_init),
    .route_lower_i   (route_lower),
    .route_upper_i   (route_upper),
    .capture_word_o  (capture_word),
    .capture_valid_o (capture_valid),
    .capture_first_o (capture_first),
    .capture_last_o  (capture_last)
  );

  initial clk_245_76MHz = 1'b0;
  always #(CLK_PERIOD / 2) clk_245_76MHz = ~clk_245_76MHz;

  // enable pulse length per burst
  function automatic int burst_len(input int idx);
    case (idx)
      0:       return 1;
      1:       return 4;
      2:       return 9;
      3:       return 23;
      default: return 12;
    endcase
  endfunction

  // keep the sign bit, drop the lsb of each sample
  function automatic iq_t halve_pair(input iq_t pair);
    logic [15:0] i_s;
    logic [15:0] q_s;
    i_s = pair[31:16];
    q_s = pair[15:0];
    return {i_s[15], i_s[15:1], q_s[15], q_s[15:1]};
  endfunction

  function automatic logic [31:0] expected_half(
    input route_sel_t  sel,
    input iq_t         adc_pair,
    input iq_t         dac_pair,
    input logic [31:0] cyc,
    input logic [31:0] smp
  );
    case (sel)
      ROUTE_ADC:          return adc_pair;
      ROUTE_DAC:          return dac_pair;
      ROUTE_SAMPLE_COUNT: return smp;
      default:            return cyc;
    endcase
  endfunction

  // expected capture word, built from the driven DDS history
  function automatic word_t expected_word(
    input route_sel_t  upper_sel,
    input route_sel_t  lower_sel,
    input logic        is_first,
    input logic        is_last,
    input logic [31:0] cyc,
    input logic [31:0] smp,
    input int          idx
  );
    iq_t dac_pair;
    iq_t adc_pair;
    dac_pair = hist_mem[idx-1];
    adc_pair = halve_pair(hist_mem[idx-1-`ADC_DELAY]);
    if (is_first || is_last) begin
      return {cyc, smp};
    end
    return {expected_half(upper_sel, adc_pair, dac_pair, cyc, smp),
            expected_half(lower_sel, adc_pair, dac_pair, cyc, smp)};
  endfunction

  task automatic stop_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("ERROR capture_word_o expected 0x%016h got 0x%016h", exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%0h got 0x%0h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input int exp, input int act);
    if (act != exp) begin
      $display("ERROR burst word count expected 0x%0h got 0x%0h", exp, act);
      stop_with_failure();
    end
  endtask

  // new DDS pair and route codes every falling edge
  always @(negedge clk_245_76MHz) begin
    if (!cpu_reset) begin
      {dds_i, dds_q} = $random(seed);
      route_step  = route_step + 4'd1;
      route_upper = route_sel_t'(route_step[1:0]);
      route_lower = route_sel_t'(route_step[3:2]);
    end
  end

  // compare on every rising edge once out of reset
  always @(posedge clk_245_76MHz) begin : compare
    int    hist_idx;
    logic  is_final;
    word_t exp_word;
    if (!cpu_reset) begin
      hist_idx = int'(tb_cycle) + HIST_OFS;
      hist_mem[hist_idx] = {dds_i, dds_q};
      if (capture_valid) begin
        is_final = (burst_words + 1 == exp_len);
        check_flag("capture_first_o", burst_words == 0, capture_first);
        check_flag("capture_last_o", is_final, capture_last);
        exp_word = expected_word(route_upper, route_lower, burst_words == 0, is_final,
                                 tb_cycle, tb_samples, hist_idx);
        check_word(exp_word, capture_word);
        burst_words = burst_words + 1;
        tb_samples  = tb_samples + 32'd1;
      end else begin
        // burst has just ended, its length is known now
        if (burst_words != 0) begin
          check_count(exp_len, burst_words);
          burst_words = 0;
          bursts_done = bursts_done + 1;
        end
        check_flag("capture_first_o", 1'b0, capture_first);
        check_flag("capture_last_o", 1'b0, capture_last);
      end
      tb_cycle = tb_cycle + 32'd1;
    end
  end

  // one enable pulse of len cycles, optionally with a chirp start at the rise
  task automatic run_burst(input int len, input logic with_chirp);
    int target;
    // a chirp start pushes the first word out, the end stays put
    exp_len = with_chirp ? len : len + `DDS_LATENCY;
    target  = bursts_done + 1;
    @(negedge clk_245_76MHz);
    adc_enable = 1'b1;
    chirp_init = with_chirp;
    @(negedge clk_245_76MHz);
    chirp_init = 1'b0;
    repeat (len - 1) @(negedge clk_245_76MHz);
    adc_enable = 1'b0;
    wait (bursts_done == target);
    repeat (4) @(negedge clk_245_76MHz);
  endtask

  initial begin : stimulus
    seed        = 32'h7187_d91d;
    cpu_reset   = 1'b1;
    dds_i       = '0;
    dds_q       = '0;
    adc_enable  = 1'b0;
    chirp_init  = 1'b0;
    route_step  = '0;
    route_lower = ROUTE_ADC;
    route_upper = ROUTE_ADC;
    tb_cycle    = '0;
    tb_samples  = '0;
    burst_words = 0;
    exp_len     = 0;
    bursts_done = 0;
    for (int k = 0; k < HIST_DEPTH; k++) begin
      hist_mem[k] = '0;
    end

    repeat (8) @(posedge clk_245_76MHz);
    @(negedge clk_245_76MHz);
    cpu_reset = 1'b0;

    // let the ADC delay line fill with real samples
    repeat (`ADC_DELAY + 4) @(negedge clk_245_76MHz);

    for (int b = 0; b < N_BURST; b++) begin
      run_burst(burst_len(b), b == N_BURST - 1);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin : watchdog
    int budget;
    budget = 0;
    for (int b = 0; b < N_BURST; b++) begin
      budget = budget + burst_len(b) + `DDS_LATENCY;
    end
    budget = budget + `ADC_DELAY + 200;
    #(budget * CLK_PERIOD);
    $display("timeout: the capture bursts did not complete within %0d cycles", budget);
    stop_with_failure();
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
capture_pkg.sv
loopback_model.sv
enable_gate.sv
capture_counters.sv
capture_word_mux.sv
capture_top.sv
tb_capture_top.sv

// ==== Bender.yml ====
package:
  name: capture_frame

sources:
  - include_dirs:
      - .
    files:
      - capture_pkg.sv
      - loopback_model.sv
      - enable_gate.sv
      - capture_counters.sv
      - capture_word_mux.sv
      - capture_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_capture_top.sv
